/* common/codec_pkg.sv */
// Codec widths, lane count, opcode type, lane request and lane result structs
`default_nettype none

package codec_pkg;

  // Lane count and the codeword geometry
  localparam int num_lanes = 2;
  localparam int data_w    = 8;
  localparam int code_w    = 12;
  localparam int syn_w     = 4;

  // Widths of the packed result and status words seen on the bus
  localparam int result_w  = num_lanes * code_w;
  localparam int status_w  = 2 * num_lanes + 1;

  // Operation carried by every lane item
  typedef enum logic {
    op_encode = 1'b0,
    op_decode = 1'b1
  } codec_op_e;

  // Request into one lane
  // On encode only the low data_w bits of payload hold the byte
  typedef struct packed {
    logic              valid;
    codec_op_e         op;
    logic [code_w-1:0] payload;
  } lane_req_t;

  // Result out of one lane
  // Encode returns the codeword, decode returns the byte in the low bits
  typedef struct packed {
    logic              valid;
    codec_op_e         op;
    logic [code_w-1:0] result;
    logic              corrected;
    logic              uncorrectable;
  } lane_res_t;

endpackage

`default_nettype wire

/* common/bus_pkg.sv */
// Wishbone widths, register address map, bus request and response structs
`default_nettype none

package bus_pkg;

  localparam int wb_adr_w = 4;
  localparam int wb_dat_w = 32;

  // Word addresses of the slave registers
  typedef enum logic [wb_adr_w-1:0] {
    reg_encode = 4'd0,
    reg_decode = 4'd1,
    reg_result = 4'd2,
    reg_status = 4'd3
  } reg_addr_e;

  // Master to slave
  typedef struct packed {
    logic                cyc;
    logic                stb;
    logic                we;
    logic [wb_adr_w-1:0] adr;
    logic [wb_dat_w-1:0] dat_w;
  } wb_req_t;

  // Slave to master
  typedef struct packed {
    logic                ack;
    logic [wb_dat_w-1:0] dat_r;
  } wb_rsp_t;

endpackage

`default_nettype wire

/* hamming/hamming_lane.sv */
// Hamming(12,8) lane with a three-stage encode and decode pipeline and its checks
`timescale 1ns/10ps
`default_nettype none

module hamming_lane (
  input  logic                 clk,
  input  logic                 rst_n,
  input  codec_pkg::lane_req_t req,
  output codec_pkg::lane_res_t res
);

  import codec_pkg::*;

  // Parity bits returned in the order p3 p2 p1 p0
  function automatic logic [syn_w-1:0] calc_parity(input logic [data_w-1:0] d);
    logic [syn_w-1:0] p;
    p[0] = d[0] ^ d[1] ^ d[3] ^ d[4] ^ d[6];
    p[1] = d[0] ^ d[2] ^ d[3] ^ d[5] ^ d[6];
    p[2] = d[1] ^ d[2] ^ d[3] ^ d[7];
    p[3] = d[4] ^ d[5] ^ d[6] ^ d[7];
    return p;
  endfunction

  // Bit 0 upward: p0 p1 d0 p2 d1 d2 d3 p3 d4 d5 d6 d7
  function automatic logic [code_w-1:0] place_code(input logic [data_w-1:0] d,
                                                   input logic [syn_w-1:0]  p);
    return {d[7:4], p[3], d[3:1], p[2], d[0], p[1], p[0]};
  endfunction

  function automatic logic [data_w-1:0] extract_data(input logic [code_w-1:0] c);
    return {c[11:8], c[6:4], c[2]};
  endfunction

  function automatic logic [syn_w-1:0] recv_parity(input logic [code_w-1:0] c);
    return {c[7], c[3], c[1], c[0]};
  endfunction

  // Stage 1 holds the raw request
  logic              s1_valid;
  codec_op_e         s1_op;
  logic [code_w-1:0] s1_word;
  logic [data_w-1:0] s1_data;
  logic [syn_w-1:0]  s1_chk;

  // Stage 2 holds the byte and either its parity or the syndrome
  logic              s2_valid;
  codec_op_e         s2_op;
  logic [data_w-1:0] s2_data;
  logic [syn_w-1:0]  s2_chk;
  logic              syn_fix;
  logic              syn_bad;
  logic [code_w-1:0] flip_mask;

  // Stage 3 is the lane output
  logic              s3_valid;
  codec_op_e         s3_op;
  logic [code_w-1:0] s3_result;
  logic              s3_corr;
  logic              s3_uncorr;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
      s3_valid <= 1'b0;
    end else begin
      s1_valid <= req.valid;
      s2_valid <= s1_valid;
      s3_valid <= s2_valid;
    end
  end

  always_ff @(posedge clk) begin
    s1_op   <= req.op;
    s1_word <= req.payload;
  end

  // Encode takes the byte as is, decode pulls it out of the codeword
  always_comb begin
    if (s1_op == op_encode) begin
      s1_data = s1_word[data_w-1:0];
      s1_chk  = calc_parity(s1_data);
    end else begin
      s1_data = extract_data(s1_word);
      s1_chk  = recv_parity(s1_word) ^ calc_parity(s1_data);
    end
  end

  always_ff @(posedge clk) begin
    s2_op   <= s1_op;
    s2_data <= s1_data;
    s2_chk  <= s1_chk;
  end

  // Syndrome 1..12 names the bad bit, 13..15 cannot come from one flip
  always_comb begin
    syn_fix   = (s2_chk != '0) && (s2_chk <= syn_w'(code_w));
    syn_bad   = s2_chk > syn_w'(code_w);
    flip_mask = '0;
    if (syn_fix) begin
      flip_mask[s2_chk - 1'b1] = 1'b1;
    end
  end

  // a flip on a parity position leaves the data bits alone
  always_ff @(posedge clk) begin
    s3_op <= s2_op;
    if (s2_op == op_encode) begin
      s3_result <= place_code(s2_data, s2_chk);
      s3_corr   <= 1'b0;
      s3_uncorr <= 1'b0;
    end else begin
      s3_result <= {{(code_w - data_w){1'b0}}, s2_data ^ extract_data(flip_mask)};
      s3_corr   <= syn_fix;
      s3_uncorr <= syn_bad;
    end
  end

  assign res = '{valid: s3_valid, op: s3_op, result: s3_result,
                 corrected: s3_corr, uncorrectable: s3_uncorr};

  // Stage 2 parity matches the byte from stage 1, each bit over its data mask
  assert property (@(posedge clk) disable iff (!rst_n)
    s2_valid && (s2_op == op_encode)
      |-> s2_chk == {^(s2_data & 8'hf0), ^(s2_data & 8'h8e),
                     ^(s2_data & 8'h6d), ^(s2_data & 8'h5b)});

  // Data positions of an encoded word carry the byte from three cycles back
  assert property (@(posedge clk) disable iff (!rst_n)
    res.valid && (res.op == op_encode)
      |-> extract_data(res.result) == $past(req.payload[data_w-1:0], 3));

  assert property (@(posedge clk) disable iff (!rst_n)
    res.valid |-> !(res.corrected && res.uncorrectable));

endmodule

`default_nettype wire

/* logic/lane_dispatch.sv */
// Wishbone write decoder that turns a bus word into per-lane requests
`timescale 1ns/10ps
`default_nettype none

module lane_dispatch (
  input  logic                 clk,
  input  logic                 rst_n,
  input  bus_pkg::wb_req_t     wb_req,
  input  logic                 ack,
  output codec_pkg::lane_req_t lane_req [codec_pkg::num_lanes],
  output logic                 direct
);

  import codec_pkg::*;
  import bus_pkg::*;

  logic              accept;
  logic              is_op;
  codec_op_e         next_op;
  logic [code_w-1:0] next_payload [num_lanes];

  logic              busy;
  logic              req_valid;
  codec_op_e         req_op;
  logic [code_w-1:0] req_payload [num_lanes];

  // Busy masks a held strobe until the ack
  assign accept = wb_req.cyc && wb_req.stb && !busy;

  // Only writes to encode or decode reach the lanes
  always_comb begin
    is_op   = 1'b0;
    next_op = op_encode;
    if (wb_req.we) begin
      case (reg_addr_e'(wb_req.adr))
        reg_encode: begin
          is_op   = 1'b1;
          next_op = op_encode;
        end
        reg_decode: begin
          is_op   = 1'b1;
          next_op = op_decode;
        end
        default: is_op = 1'b0;
      endcase
    end
  end

  // Bytes pack 8 bits per lane, codewords 12 bits per lane
  always_comb begin
    for (int i = 0; i < num_lanes; i++) begin
      if (next_op == op_decode) begin
        next_payload[i] = wb_req.dat_w[code_w*i +: code_w];
      end else begin
        next_payload[i] = {{(code_w - data_w){1'b0}}, wb_req.dat_w[data_w*i +: data_w]};
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy      <= 1'b0;
      req_valid <= 1'b0;
      direct    <= 1'b0;
    end else begin
      req_valid <= accept && is_op;
      direct    <= accept && !is_op;
      if (accept) begin
        busy <= 1'b1;
      end else if (ack) begin
        busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      req_op      <= next_op;
      req_payload <= next_payload;
    end
  end

  always_comb begin
    for (int i = 0; i < num_lanes; i++) begin
      lane_req[i] = '{valid: req_valid, op: req_op, payload: req_payload[i]};
    end
  end

endmodule

`default_nettype wire

/* logic/lane_collect.sv */
// Lane result packer with result and status registers, Wishbone ack and read mux
`timescale 1ns/10ps
`default_nettype none

module lane_collect (
  input  logic                 clk,
  input  logic                 rst_n,
  input  codec_pkg::lane_res_t lane_res [codec_pkg::num_lanes],
  input  logic                 direct,
  input  bus_pkg::wb_req_t     wb_req,
  output bus_pkg::wb_rsp_t     wb_rsp
);

  import codec_pkg::*;
  import bus_pkg::*;

  logic [num_lanes-1:0] res_valid;
  logic                 all_valid;
  logic [wb_dat_w-1:0]  read_data;

  logic                 ack_q;
  logic [result_w-1:0]  result_q;
  logic [status_w-1:0]  status_q;
  logic [wb_dat_w-1:0]  dat_r_q;

  always_comb begin
    for (int i = 0; i < num_lanes; i++) begin
      res_valid[i] = lane_res[i].valid;
    end
  end

  assign all_valid = &res_valid;

  // Reads of anything but result or status return zero
  always_comb begin
    read_data = '0;
    if (!wb_req.we) begin
      case (reg_addr_e'(wb_req.adr))
        reg_result: read_data = {{(wb_dat_w - result_w){1'b0}}, result_q};
        reg_status: read_data = {{(wb_dat_w - status_w){1'b0}}, status_q};
        default:    read_data = '0;
      endcase
    end
  end

  // Status layout: corrected flags, then uncorrectable flags, then opcode
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ack_q    <= 1'b0;
      result_q <= '0;
      status_q <= '0;
    end else begin
      ack_q <= all_valid || direct;
      if (all_valid) begin
        for (int i = 0; i < num_lanes; i++) begin
          result_q[code_w*i +: code_w] <= lane_res[i].result;
          status_q[i]                  <= lane_res[i].corrected;
          status_q[num_lanes + i]      <= lane_res[i].uncorrectable;
        end
        status_q[2*num_lanes] <= lane_res[0].op;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (direct) begin
      dat_r_q <= read_data;
    end else if (all_valid) begin
      dat_r_q <= '0;
    end
  end

  assign wb_rsp = '{ack: ack_q, dat_r: dat_r_q};

  // One outstanding transaction means a single-cycle ack
  assert property (@(posedge clk) disable iff (!rst_n) ack_q |=> !ack_q);

  // Lanes run in lockstep so their results land together
  assert property (@(posedge clk) disable iff (!rst_n) (|res_valid) |-> all_valid);

endmodule

`default_nettype wire

/* logic/hamming_codec_top.sv */
// Codec top with the bus dispatcher, the generated Hamming lanes and the collector
`timescale 1ns/10ps
`default_nettype none

module hamming_codec_top (
  input  logic             clk,
  input  logic             rst_n,
  input  bus_pkg::wb_req_t wb_req,
  output bus_pkg::wb_rsp_t wb_rsp
);

  import codec_pkg::*;

  // Per-lane request and result buses
  lane_req_t lane_req [num_lanes];
  lane_res_t lane_res [num_lanes];

  // Register accesses that skip the lanes
  logic direct;

  lane_dispatch lane_dispatch_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_req   (wb_req),
    .ack      (wb_rsp.ack),
    .lane_req (lane_req),
    .direct   (direct)
  );

  // Identical lanes, one per slice of the bus word
  for (genvar i = 0; i < num_lanes; i++) begin : g_lane
    hamming_lane hamming_lane_i (
      .clk   (clk),
      .rst_n (rst_n),
      .req   (lane_req[i]),
      .res   (lane_res[i])
    );
  end

  lane_collect lane_collect_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .lane_res (lane_res),
    .direct   (direct),
    .wb_req   (wb_req),
    .wb_rsp   (wb_rsp)
  );

endmodule

`default_nettype wire

/* test/tb_hamming_checks.svh */
// Error counters and typed compare tasks for codewords, bytes, status bits and ack latency
`ifndef TB_HAMMING_CHECKS_SVH
`define TB_HAMMING_CHECKS_SVH

  // Wrong values and other failures are counted apart
  int mismatch_count = 0;
  int failure_count  = 0;

  task automatic check_code(input string name, input logic [code_w-1:0] expected,
                            input logic [code_w-1:0] actual);
    if (actual !== expected) begin
      mismatch_count++;
      $display("MISMATCH %s: expected %03h, actual %03h", name, expected, actual);
    end
  endtask

  task automatic check_data(input string name, input logic [data_w-1:0] expected,
                            input logic [data_w-1:0] actual);
    if (actual !== expected) begin
      mismatch_count++;
      $display("MISMATCH %s: expected %02h, actual %02h", name, expected, actual);
    end
  endtask

  // Status bits are op, uncorrectable flags, corrected flags from the top down
  task automatic check_status(input string name, input logic [status_w-1:0] expected,
                              input logic [status_w-1:0] actual);
    if (actual !== expected) begin
      mismatch_count++;
      $display("MISMATCH %s: expected %b, actual %b", name, expected, actual);
    end
  endtask

  // Latency in clock cycles from the first strobe cycle to the ack
  task automatic check_latency(input string name, input int expected, input int actual);
    if (actual != expected) begin
      mismatch_count++;
      $display("MISMATCH %s: expected %0d, actual %0d", name, expected, actual);
    end
  endtask

  task automatic report_failure(input string what);
    failure_count++;
    $display("ERROR %s at %0t", what, $time);
  endtask

`endif

/* test/tb_hamming_codec.sv */
// Testbench top for the Hamming codec with clock, reset, bus tasks, reference model and tests
`timescale 1ns/10ps
`default_nettype none

module tb_hamming_codec;

  import codec_pkg::*;
  import bus_pkg::*;

  localparam int ack_timeout = 20;

  logic    clk = 1'b0;
  logic    rst_n;
  wb_req_t wb_req;
  wb_rsp_t wb_rsp;

  int                                seed;
  int                                last_latency;
  logic [num_lanes-1:0][code_w-1:0] exp_result;
  logic [status_w-1:0]               exp_status;

  `include "tb_hamming_checks.svh"

  hamming_codec_top hamming_codec_top_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp)
  );

  always #50 clk = ~clk;

  // Positions counted from 1; powers of two hold parity, the rest hold data in order
  function automatic logic [code_w-1:0] ref_encode(input logic [data_w-1:0] d);
    logic [code_w-1:0] c;
    int                k;
    c = '0;
    k = 0;
    for (int pos = 1; pos <= code_w; pos++) begin
      if ((pos & (pos - 1)) != 0) begin
        c[pos-1] = d[k];
        k++;
      end
    end
    // Parity bit b covers every position whose index has bit b set
    for (int b = 0; b < syn_w; b++) begin
      for (int pos = 1; pos <= code_w; pos++) begin
        if (pos[b] && pos != (1 << b)) begin
          c[(1 << b) - 1] ^= c[pos-1];
        end
      end
    end
    return c;
  endfunction

  function automatic lane_res_t ref_decode(input logic [code_w-1:0] c);
    logic [syn_w-1:0]  syn;
    logic [code_w-1:0] fixed;
    logic [data_w-1:0] d;
    logic              corr;
    int                k;
    // Syndrome is the XOR of the positions of all set bits
    syn = '0;
    for (int pos = 1; pos <= code_w; pos++) begin
      if (c[pos-1]) begin
        syn ^= syn_w'(pos);
      end
    end
    corr  = (syn != '0) && (syn <= syn_w'(code_w));
    fixed = c;
    if (corr) begin
      fixed[syn - 1'b1] = ~fixed[syn - 1'b1];
    end
    k = 0;
    d = '0;
    for (int pos = 1; pos <= code_w; pos++) begin
      if ((pos & (pos - 1)) != 0) begin
        d[k] = fixed[pos-1];
        k++;
      end
    end
    return '{valid: 1'b1, op: op_decode, result: code_w'(d),
             corrected: corr, uncorrectable: syn > syn_w'(code_w)};
  endfunction

  // One classic cycle, driven on the falling edge, ack sampled there too
  task automatic bus_access(input logic we, input reg_addr_e adr,
                            input logic [wb_dat_w-1:0] wdata,
                            output logic [wb_dat_w-1:0] rdata);
    logic acked;
    @(negedge clk);
    wb_req       = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat_w: wdata};
    acked        = 1'b0;
    rdata        = '0;
    last_latency = 0;
    while (!acked && last_latency < ack_timeout) begin
      @(negedge clk);
      last_latency++;
      acked = wb_rsp.ack;
    end
    if (acked) begin
      rdata = wb_rsp.dat_r;
    end else begin
      report_failure($sformatf("no acknowledge from DUT for address %0d", adr));
    end
    wb_req = '0;
  endtask

  task automatic bus_write(input reg_addr_e adr, input logic [wb_dat_w-1:0] wdata);
    logic [wb_dat_w-1:0] unused;
    bus_access(1'b1, adr, wdata, unused);
  endtask

  task automatic bus_read(input reg_addr_e adr, output logic [wb_dat_w-1:0] rdata);
    bus_access(1'b0, adr, '0, rdata);
  endtask

  // Reads result and status back and compares them with the expected registers
  task automatic check_registers(input string name,
                                 output logic [num_lanes-1:0][code_w-1:0] got);
    logic [wb_dat_w-1:0] rd;
    bus_read(reg_result, rd);
    check_latency({name, " result read ack"}, 2, last_latency);
    for (int i = 0; i < num_lanes; i++) begin
      got[i] = rd[code_w*i +: code_w];
      check_code($sformatf("%s lane%0d result", name, i), exp_result[i], got[i]);
    end
    bus_read(reg_status, rd);
    check_latency({name, " status read ack"}, 2, last_latency);
    check_status({name, " status"}, exp_status, rd[status_w-1:0]);
  endtask

  task automatic run_encode(input string name, input logic [num_lanes-1:0][data_w-1:0] d,
                            output logic [num_lanes-1:0][code_w-1:0] cw);
    bus_write(reg_encode, wb_dat_w'(d));
    check_latency({name, " write ack"}, 5, last_latency);
    for (int i = 0; i < num_lanes; i++) begin
      exp_result[i] = ref_encode(d[i]);
    end
    exp_status = {op_encode, {(2 * num_lanes){1'b0}}};
    check_registers(name, cw);
  endtask

  task automatic run_decode(input string name, input logic [num_lanes-1:0][code_w-1:0] cw,
                            output logic [num_lanes-1:0][code_w-1:0] got);
    lane_res_t            expected;
    logic [num_lanes-1:0] corr;
    logic [num_lanes-1:0] uncorr;
    bus_write(reg_decode, wb_dat_w'(cw));
    check_latency({name, " write ack"}, 5, last_latency);
    for (int i = 0; i < num_lanes; i++) begin
      expected      = ref_decode(cw[i]);
      exp_result[i] = expected.result;
      corr[i]       = expected.corrected;
      uncorr[i]     = expected.uncorrectable;
    end
    exp_status = {op_decode, uncorr, corr};
    check_registers(name, got);
  endtask

  initial begin
    logic [num_lanes-1:0][data_w-1:0] bytes;
    logic [num_lanes-1:0][code_w-1:0] cw;
    logic [num_lanes-1:0][code_w-1:0] got;
    logic [wb_dat_w-1:0]              rd;
    logic [data_w-1:0]                patterns [4];
    seed     = 32'he73c3dc8;
    patterns = '{8'h00, 8'hff, 8'ha5, 8'h3c};
    wb_req   = '0;
    rst_n    = 1'b0;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;

    exp_result = '0;
    exp_status = '0;
    check_registers("after reset", got);

    foreach (patterns[i]) begin
      run_encode($sformatf("encode %02h", patterns[i]), {2{patterns[i]}}, cw);
    end

    // Reference codewords of the encoded bytes go into decode
    repeat (8) begin
      bytes = 16'($random(seed));
      run_encode("round trip encode", bytes, got);
      for (int i = 0; i < num_lanes; i++) begin
        cw[i] = ref_encode(bytes[i]);
      end
      run_decode("round trip decode", cw, got);
      for (int i = 0; i < num_lanes; i++) begin
        check_data("round trip data", bytes[i], got[i][data_w-1:0]);
      end
    end

    bytes = 16'($random(seed));
    for (int pos = 0; pos < code_w; pos++) begin
      cw[0] = ref_encode(bytes[0]) ^ (code_w'(1) << pos);
      cw[1] = ref_encode(bytes[1]);
      run_decode($sformatf("single flip bit %0d", pos), cw, got);
      check_data("single flip lane0 data", bytes[0], got[0][data_w-1:0]);
      check_data("single flip lane1 data", bytes[1], got[1][data_w-1:0]);
      bus_read(reg_status, rd);
      check_status("single flip flags", 5'b1_00_01, rd[status_w-1:0]);
    end

    // All double flips, some of which land on syndromes 13 to 15
    for (int a = 0; a < code_w; a++) begin
      for (int b = a + 1; b < code_w; b++) begin
        bytes = 16'($random(seed));
        cw[0] = ref_encode(bytes[0]) ^ (code_w'(1) << a) ^ (code_w'(1) << b);
        cw[1] = ref_encode(bytes[1]);
        run_decode($sformatf("double flip bits %0d %0d", a, b), cw, got);
      end
    end

    bus_read(reg_encode, rd);
    check_latency("encode read ack", 2, last_latency);
    for (int i = 0; i < num_lanes; i++) begin
      check_code($sformatf("encode read lane%0d", i), '0, rd[code_w*i +: code_w]);
    end
    bus_write(reg_result, '1);
    check_latency("result write ack", 2, last_latency);
    check_registers("after result write", got);

    $display("Errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
    if (mismatch_count == 0 && failure_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
+incdir+test
common/codec_pkg.sv
common/bus_pkg.sv
hamming/hamming_lane.sv
logic/lane_dispatch.sv
logic/lane_collect.sv
logic/hamming_codec_top.sv
test/tb_hamming_codec.sv

/* run_sim.sh */
#!/bin/sh
# Build the codec testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sources.f \
  --top-module tb_hamming_codec -Mdir obj_dir

out=$(./obj_dir/Vtb_hamming_codec)
echo "$out"

if echo "$out" | grep -qx "Testbench passed"; then
  exit 0
fi
exit 1
